// File: design/turf_wb_pkg.sv
package turf_wb_pkg;

    //////////////////////////////////////////////////
    // Register bus geometry
    //////////////////////////////////////////////////

    // Full register space, byte addressed
    localparam int WB_ADDR_W = 28;
    localparam int WB_DATA_W = 32;

    // TURFIO links behind the crate bridge
    localparam int NUM_LINKS = 4;
    localparam int LINK_SEL_W = $clog2(NUM_LINKS);
    // Crate space seen by one link (bit 27 dropped)
    localparam int LINK_ADR_W = WB_ADDR_W - 1;

    //////////////////////////////////////////////////
    // Wishbone classic request/response
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    // err only ever rides along with ack
    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    //////////////////////////////////////////////////
    // Link command/response, valid is one cycle
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [LINK_SEL_W-1:0] link;
        logic [LINK_ADR_W-1:0] adr;
        logic [WB_DATA_W-1:0]  dat;
    } link_cmd_t;

    typedef struct packed {
        logic                 valid;
        logic [WB_DATA_W-1:0] dat;
    } link_rsp_t;

endpackage

// File: design/turf_id_pkg.sv
package turf_id_pkg;

    //////////////////////////////////////////////////
    // Identity
    //////////////////////////////////////////////////

    // ASCII "TURF"
    localparam logic [31:0] TURF_IDENT = 32'h5455_5246;
    // Version 0.2.1, date field left zero
    localparam logic [31:0] TURF_DATEVERSION = 32'h0000_0201;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // ID/control block decodes the low 14 bits
    localparam int ID_ADR_W = 14;
    localparam logic [ID_ADR_W-1:0] REG_IDENT       = 'h00;
    localparam logic [ID_ADR_W-1:0] REG_DATEVERSION = 'h04;
    localparam logic [ID_ADR_W-1:0] REG_BRIDGE_CTRL = 'h08;
    localparam logic [ID_ADR_W-1:0] REG_BRIDGE_STAT = 'h0C;

    // Top address bit selects crate space
    localparam int CRATE_SPACE_BIT = 27;

    //////////////////////////////////////////////////
    // Crate bridge
    //////////////////////////////////////////////////

    // Cycles to wait for a link response
    localparam int BRIDGE_TIMEOUT = 64;
    localparam int BRIDGE_CNT_W = $clog2(BRIDGE_TIMEOUT);
    // Returned on refusal or timeout
    localparam logic [turf_wb_pkg::WB_DATA_W-1:0] BAD_ACCESS_DATA = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1
    } bridge_type_e;

    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,
        BR_WAIT = 2'd1,
        BR_DONE = 2'd2
    } bridge_state_e;

endpackage

// File: design/turf_wb_arbiter.sv
`timescale 1ns/1ps
module turf_wb_arbiter (
    input  logic                 arst_n_i,
    input  logic                 ps_clk,
    input  turf_wb_pkg::wb_req_t ps_req_i,
    input  turf_wb_pkg::wb_req_t eth_req_i,
    input  turf_wb_pkg::wb_rsp_t bus_rsp_i,
    output turf_wb_pkg::wb_rsp_t ps_rsp_o,
    output turf_wb_pkg::wb_rsp_t eth_rsp_o,
    output turf_wb_pkg::wb_req_t bus_req_o
);

    // Bus owned by some master
    logic busy_q;
    // Owner while busy, last served while idle
    logic last_eth_q;

    logic ps_want;
    logic eth_want;
    logic pick_eth;

    // Master requests a cycle
    assign ps_want  = ps_req_i.cyc & ps_req_i.stb;
    assign eth_want = eth_req_i.cyc & eth_req_i.stb;

    // On contention the master not served last wins
    assign pick_eth = eth_want & (~ps_want | ~last_eth_q);

    //////////////////////////////////////////////////
    // Grant state
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            last_eth_q <= 1'b0;
        end else if (busy_q) begin
            // Release once the owner sees its ack
            if (bus_rsp_i.ack) begin
                busy_q <= 1'b0;
            end
        end else if (ps_want | eth_want) begin
            // New grant only from idle
            busy_q     <= 1'b1;
            last_eth_q <= pick_eth;
        end
    end

    //////////////////////////////////////////////////
    // Request and response steering
    //////////////////////////////////////////////////

    always_comb begin
        bus_req_o = '0;
        ps_rsp_o  = '0;
        eth_rsp_o = '0;
        if (busy_q) begin
            if (last_eth_q) begin
                bus_req_o = eth_req_i;
                eth_rsp_o = bus_rsp_i;
            end else begin
                bus_req_o = ps_req_i;
                ps_rsp_o  = bus_rsp_i;
            end
        end
    end

endmodule

// File: design/turf_wb_decoder.sv
`timescale 1ns/1ps
module turf_wb_decoder (
    input  logic                 arst_n_i,
    input  logic                 ps_clk,
    input  turf_wb_pkg::wb_req_t bus_req_i,
    output turf_wb_pkg::wb_rsp_t bus_rsp_o,
    output turf_wb_pkg::wb_req_t id_req_o,
    output turf_wb_pkg::wb_req_t br_req_o,
    input  turf_wb_pkg::wb_rsp_t id_rsp_i,
    input  turf_wb_pkg::wb_rsp_t br_rsp_i
);

    logic sel_br;
    logic sel_id;
    logic sel_none;
    // Error ack for unmapped space
    logic err_ack_q;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    // Crate space wins over everything
    assign sel_br = bus_req_i.adr[turf_id_pkg::CRATE_SPACE_BIT];
    // ID block needs all upper bits clear
    assign sel_id = ~sel_br &
        (bus_req_i.adr[turf_wb_pkg::WB_ADDR_W-1:turf_id_pkg::ID_ADR_W] == '0);
    // GBE, Aurora, control and event spaces land here
    assign sel_none = ~sel_br & ~sel_id;

    // Gate the strobe to the selected peer only
    always_comb begin
        id_req_o     = bus_req_i;
        id_req_o.cyc = bus_req_i.cyc & sel_id;
        id_req_o.stb = bus_req_i.stb & sel_id;
        br_req_o     = bus_req_i;
        br_req_o.cyc = bus_req_i.cyc & sel_br;
        br_req_o.stb = bus_req_i.stb & sel_br;
    end

    // One-cycle error ack, no peer involved
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= bus_req_i.cyc & bus_req_i.stb & sel_none & ~err_ack_q;
        end
    end

    //////////////////////////////////////////////////
    // Response return
    //////////////////////////////////////////////////

    always_comb begin
        if (sel_br) begin
            bus_rsp_o = br_rsp_i;
        end else if (sel_id) begin
            bus_rsp_o = id_rsp_i;
        end else begin
            bus_rsp_o     = '0;
            bus_rsp_o.ack = err_ack_q;
            bus_rsp_o.err = err_ack_q;
        end
    end

endmodule

// File: design/turf_id_ctrl.sv
`timescale 1ns/1ps
module turf_id_ctrl (
    input  logic                                  arst_n_i,
    input  logic                                  ps_clk,
    input  turf_wb_pkg::wb_req_t                  req_i,
    output turf_wb_pkg::wb_rsp_t                  rsp_o,
    input  logic [turf_wb_pkg::NUM_LINKS-1:0]     timeout_i,
    input  logic [turf_wb_pkg::NUM_LINKS-1:0]     invalid_i,
    output logic [turf_wb_pkg::LINK_SEL_W-1:0]    bridge_link_o,
    output turf_id_pkg::bridge_type_e             bridge_type_o
);

    logic                                 ack_q;
    logic [turf_wb_pkg::WB_DATA_W-1:0]    rdata_q;
    logic [turf_wb_pkg::WB_DATA_W-1:0]    rd_data;
    logic [turf_id_pkg::ID_ADR_W-1:0]     offset;
    logic                                 access;
    logic                                 wr_ctrl;
    logic                                 wr_stat;
    logic [turf_wb_pkg::NUM_LINKS-1:0]    clr_timeout;
    logic [turf_wb_pkg::NUM_LINKS-1:0]    clr_invalid;

    // Control register
    turf_id_pkg::bridge_type_e            bridge_type_q;
    logic [turf_wb_pkg::LINK_SEL_W-1:0]   bridge_link_q;
    // Sticky bridge errors, one bit per link
    logic [turf_wb_pkg::NUM_LINKS-1:0]    timeout_flags_q;
    logic [turf_wb_pkg::NUM_LINKS-1:0]    invalid_flags_q;

    assign offset = req_i.adr[turf_id_pkg::ID_ADR_W-1:0];
    // First cycle of a strobe only
    assign access  = req_i.cyc & req_i.stb & ~ack_q;
    assign wr_ctrl = access & req_i.we & (offset == turf_id_pkg::REG_BRIDGE_CTRL);
    assign wr_stat = access & req_i.we & (offset == turf_id_pkg::REG_BRIDGE_STAT);

    // Write-1-to-clear masks
    assign clr_timeout = wr_stat ? req_i.dat[turf_wb_pkg::NUM_LINKS-1:0] : '0;
    assign clr_invalid = wr_stat ?
        req_i.dat[2*turf_wb_pkg::NUM_LINKS-1:turf_wb_pkg::NUM_LINKS] : '0;

    //////////////////////////////////////////////////
    // Register state
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q           <= 1'b0;
            bridge_type_q   <= turf_id_pkg::BRIDGE_NONE;
            bridge_link_q   <= '0;
            timeout_flags_q <= '0;
            invalid_flags_q <= '0;
        end else begin
            ack_q <= access;
            if (wr_ctrl) begin
                bridge_type_q <= turf_id_pkg::bridge_type_e'(req_i.dat[1:0]);
                bridge_link_q <= req_i.dat[5:4];
            end
            // New pulse beats a clear in the same cycle
            timeout_flags_q <= (timeout_flags_q & ~clr_timeout) | timeout_i;
            invalid_flags_q <= (invalid_flags_q & ~clr_invalid) | invalid_i;
        end
    end

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_comb begin
        rd_data = '0;
        case (offset)
            turf_id_pkg::REG_IDENT:       rd_data = turf_id_pkg::TURF_IDENT;
            turf_id_pkg::REG_DATEVERSION: rd_data = turf_id_pkg::TURF_DATEVERSION;
            turf_id_pkg::REG_BRIDGE_CTRL: begin
                rd_data[1:0] = bridge_type_q;
                rd_data[5:4] = bridge_link_q;
            end
            turf_id_pkg::REG_BRIDGE_STAT: begin
                rd_data[turf_wb_pkg::NUM_LINKS-1:0] = timeout_flags_q;
                rd_data[2*turf_wb_pkg::NUM_LINKS-1:turf_wb_pkg::NUM_LINKS] = invalid_flags_q;
            end
            default: rd_data = '0;
        endcase
    end

    // Captured alongside the ack
    always_ff @(posedge ps_clk) begin
        if (access) begin
            rdata_q <= rd_data;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;
    assign rsp_o.dat = rdata_q;

    assign bridge_type_o = bridge_type_q;
    assign bridge_link_o = bridge_link_q;

endmodule

// File: design/turfio_register_bridge.sv
`timescale 1ns/1ps
module turfio_register_bridge (
    input  logic                                arst_n_i,
    input  logic                                ps_clk,
    input  turf_wb_pkg::wb_req_t                req_i,
    output turf_wb_pkg::wb_rsp_t                rsp_o,
    input  logic [turf_wb_pkg::LINK_SEL_W-1:0]  bridge_link_i,
    input  turf_id_pkg::bridge_type_e           bridge_type_i,
    input  logic [turf_wb_pkg::NUM_LINKS-1:0]   aurora_up_i,
    output turf_wb_pkg::link_cmd_t              link_cmd_o,
    input  turf_wb_pkg::link_rsp_t              link_rsp_i,
    output logic [turf_wb_pkg::NUM_LINKS-1:0]   timeout_o,
    output logic [turf_wb_pkg::NUM_LINKS-1:0]   invalid_o
);

    turf_id_pkg::bridge_state_e             state_q;
    logic [turf_id_pkg::BRIDGE_CNT_W-1:0]   cnt_q;
    turf_wb_pkg::link_cmd_t                 cmd_q;
    logic [turf_wb_pkg::WB_DATA_W-1:0]      rdata_q;
    logic [turf_wb_pkg::NUM_LINKS-1:0]      timeout_q;
    logic [turf_wb_pkg::NUM_LINKS-1:0]      invalid_q;

    logic access;
    logic link_ok;
    logic refuse;
    logic forward;
    logic got_rsp;
    logic expired;

    // New strobe only while idle
    assign access = req_i.cyc & req_i.stb & (state_q == turf_id_pkg::BR_IDLE);
    // Needs Aurora type and the selected link up
    assign link_ok = (bridge_type_i == turf_id_pkg::BRIDGE_AURORA) &
                     aurora_up_i[bridge_link_i];
    assign refuse  = access & ~link_ok;
    assign forward = access & link_ok;

    // Waiting on the link
    assign got_rsp = (state_q == turf_id_pkg::BR_WAIT) & link_rsp_i.valid;
    assign expired = (state_q == turf_id_pkg::BR_WAIT) & ~link_rsp_i.valid &
        (cnt_q == turf_id_pkg::BRIDGE_CNT_W'(turf_id_pkg::BRIDGE_TIMEOUT - 1));

    //////////////////////////////////////////////////
    // FSM, command and error pulses
    //////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= turf_id_pkg::BR_IDLE;
            cnt_q     <= '0;
            cmd_q     <= '0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            // Command valid is a single pulse
            cmd_q.valid <= 1'b0;
            invalid_q   <= refuse ? (turf_wb_pkg::NUM_LINKS'(1) << bridge_link_i) : '0;
            timeout_q   <= expired ? (turf_wb_pkg::NUM_LINKS'(1) << cmd_q.link) : '0;
            case (state_q)
                turf_id_pkg::BR_IDLE: begin
                    if (forward) begin
                        cmd_q.valid <= 1'b1;
                        cmd_q.we    <= req_i.we;
                        cmd_q.link  <= bridge_link_i;
                        cmd_q.adr   <= req_i.adr[turf_wb_pkg::LINK_ADR_W-1:0];
                        cmd_q.dat   <= req_i.dat;
                        cnt_q       <= '0;
                        state_q     <= turf_id_pkg::BR_WAIT;
                    end else if (refuse) begin
                        state_q <= turf_id_pkg::BR_DONE;
                    end
                end
                turf_id_pkg::BR_WAIT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (got_rsp | expired) begin
                        state_q <= turf_id_pkg::BR_DONE;
                    end
                end
                // Ack cycle
                default: state_q <= turf_id_pkg::BR_IDLE;
            endcase
        end
    end

    // Response or bad-access word
    always_ff @(posedge ps_clk) begin
        if (got_rsp) begin
            rdata_q <= link_rsp_i.dat;
        end else if (refuse | expired) begin
            rdata_q <= turf_id_pkg::BAD_ACCESS_DATA;
        end
    end

    assign rsp_o.ack = (state_q == turf_id_pkg::BR_DONE);
    assign rsp_o.err = 1'b0;
    assign rsp_o.dat = rdata_q;

    assign link_cmd_o = cmd_q;
    assign timeout_o  = timeout_q;
    assign invalid_o  = invalid_q;

endmodule

// File: design/turf_regs_top.sv
`timescale 1ns/1ps
module turf_regs_top (
    input  logic                               ps_clk,
    input  logic                               arst_n_i,
    input  turf_wb_pkg::wb_req_t               ps_req_i,
    input  turf_wb_pkg::wb_req_t               eth_req_i,
    output turf_wb_pkg::wb_rsp_t               ps_rsp_o,
    output turf_wb_pkg::wb_rsp_t               eth_rsp_o,
    input  logic [turf_wb_pkg::NUM_LINKS-1:0]  aurora_up_i,
    output turf_wb_pkg::link_cmd_t             link_cmd_o,
    input  turf_wb_pkg::link_rsp_t             link_rsp_i
);

    // Shared bus after the arbiter
    turf_wb_pkg::wb_req_t bus_req;
    turf_wb_pkg::wb_rsp_t bus_rsp;
    // Peer ports
    turf_wb_pkg::wb_req_t id_req;
    turf_wb_pkg::wb_rsp_t id_rsp;
    turf_wb_pkg::wb_req_t br_req;
    turf_wb_pkg::wb_rsp_t br_rsp;

    // Bridge setup and error sideband
    logic [turf_wb_pkg::LINK_SEL_W-1:0] bridge_link;
    turf_id_pkg::bridge_type_e          bridge_type;
    logic [turf_wb_pkg::NUM_LINKS-1:0]  timeout_pulse;
    logic [turf_wb_pkg::NUM_LINKS-1:0]  invalid_pulse;

    //////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////

    turf_wb_arbiter u_arbiter (
        .arst_n_i (arst_n_i),
        .ps_clk   (ps_clk),
        .ps_req_i (ps_req_i),
        .eth_req_i(eth_req_i),
        .bus_rsp_i(bus_rsp),
        .ps_rsp_o (ps_rsp_o),
        .eth_rsp_o(eth_rsp_o),
        .bus_req_o(bus_req)
    );

    turf_wb_decoder u_decoder (
        .arst_n_i (arst_n_i),
        .ps_clk   (ps_clk),
        .bus_req_i(bus_req),
        .bus_rsp_o(bus_rsp),
        .id_req_o (id_req),
        .br_req_o (br_req),
        .id_rsp_i (id_rsp),
        .br_rsp_i (br_rsp)
    );

    //////////////////////////////////////////////////
    // Register peers
    //////////////////////////////////////////////////

    turf_id_ctrl u_idctrl (
        .arst_n_i     (arst_n_i),
        .ps_clk       (ps_clk),
        .req_i        (id_req),
        .rsp_o        (id_rsp),
        .timeout_i    (timeout_pulse),
        .invalid_i    (invalid_pulse),
        .bridge_link_o(bridge_link),
        .bridge_type_o(bridge_type)
    );

    turfio_register_bridge u_bridge (
        .arst_n_i     (arst_n_i),
        .ps_clk       (ps_clk),
        .req_i        (br_req),
        .rsp_o        (br_rsp),
        .bridge_link_i(bridge_link),
        .bridge_type_i(bridge_type),
        .aurora_up_i  (aurora_up_i),
        .link_cmd_o   (link_cmd_o),
        .link_rsp_i   (link_rsp_i),
        .timeout_o    (timeout_pulse),
        .invalid_o    (invalid_pulse)
    );

endmodule

// File: verification/turf_regs_tb.sv
`timescale 1ns/1ps
module turf_regs_tb;

    logic                   ps_clk;
    logic                   arst_n;
    turf_wb_pkg::wb_req_t   ps_req;
    turf_wb_pkg::wb_req_t   eth_req;
    turf_wb_pkg::wb_rsp_t   ps_rsp;
    turf_wb_pkg::wb_rsp_t   eth_rsp;
    logic [3:0]             aurora_up;
    turf_wb_pkg::link_cmd_t link_cmd;
    turf_wb_pkg::link_rsp_t link_rsp;

    // Expected response per master, index 0 is PS and 1 is Ethernet
    logic [31:0]            exp_dat [2];
    logic                   exp_err [2];
    logic                   chk_dat [2];
    // Expected link command and whether one may appear at all
    turf_wb_pkg::link_cmd_t exp_cmd;
    logic                   cmd_allowed;
    logic                   link_silent;
    // Order in which masters saw their ack
    int                     served [$];
    integer                 seed = 32'ha9a8e9d9;
    logic [27:0]            rnd_adr;

    turf_regs_top i_turf_regs_top (
        .ps_clk     (ps_clk),
        .arst_n_i   (arst_n),
        .ps_req_i   (ps_req),
        .eth_req_i  (eth_req),
        .ps_rsp_o   (ps_rsp),
        .eth_rsp_o  (eth_rsp),
        .aurora_up_i(aurora_up),
        .link_cmd_o (link_cmd),
        .link_rsp_i (link_rsp)
    );

    // 100 ns period
    always #50 ps_clk = ~ps_clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Link model reply, tied to the command so the test can predict it
    function automatic logic [31:0] link_reply_word(input turf_wb_pkg::link_cmd_t cmd);
        return {cmd.we, cmd.link, cmd.adr, 2'b10} ^ 32'h5A5A_A5A5;
    endfunction

    task automatic expect_cmd(input logic we, input logic [1:0] link,
                              input logic [27:0] adr, input logic [31:0] dat);
        exp_cmd.valid = 1'b1;
        exp_cmd.we    = we;
        exp_cmd.link  = link;
        exp_cmd.adr   = adr[26:0];
        exp_cmd.dat   = dat;
    endtask

    // One Wishbone cycle from master m, exp_lat below 0 skips the latency check
    task automatic bus_access(input int m, input logic we, input logic [27:0] adr,
                              input logic [31:0] dat, input logic [31:0] exp,
                              input logic exp_e, input int exp_lat);
        turf_wb_pkg::wb_req_t req;
        turf_wb_pkg::wb_rsp_t rsp;
        int                   cycles;
        req.cyc    = 1'b1;
        req.stb    = 1'b1;
        req.we     = we;
        req.adr    = adr;
        req.dat    = dat;
        exp_dat[m] = exp;
        exp_err[m] = exp_e;
        // Write data coming back is don't care
        chk_dat[m] = ~we;
        if (m == 0) ps_req = req;
        else eth_req = req;
        cycles = 0;
        rsp    = '0;
        // Sample away from the rising edge
        while (!rsp.ack) begin
            @(negedge ps_clk);
            rsp = (m == 0) ? ps_rsp : eth_rsp;
            if (!rsp.ack) cycles++;
        end
        if (exp_lat >= 0) begin
            assert (cycles == exp_lat)
            else stop_on_error($sformatf("mismatch ack latency expected %h actual %h",
                                         exp_lat, cycles));
        end
        served.push_back(m);
        @(posedge ps_clk);
        #1;
        if (m == 0) ps_req = '0;
        else eth_req = '0;
    endtask

    //////////////////////////////////////////////////
    // Protocol and response checks
    //////////////////////////////////////////////////

    a_ps_err: assert property (@(posedge ps_clk) disable iff (!arst_n)
        ps_rsp.err |-> ps_rsp.ack)
        else stop_on_error("PS master saw err without ack");
    a_eth_err: assert property (@(posedge ps_clk) disable iff (!arst_n)
        eth_rsp.err |-> eth_rsp.ack)
        else stop_on_error("Ethernet master saw err without ack");
    a_ps_ack_pulse: assert property (@(posedge ps_clk) disable iff (!arst_n)
        ps_rsp.ack |=> !ps_rsp.ack)
        else stop_on_error("PS ack lasted longer than one cycle");
    a_eth_ack_pulse: assert property (@(posedge ps_clk) disable iff (!arst_n)
        eth_rsp.ack |=> !eth_rsp.ack)
        else stop_on_error("Ethernet ack lasted longer than one cycle");
    a_ps_rsp_err: assert property (@(posedge ps_clk) disable iff (!arst_n)
        ps_rsp.ack |-> ps_rsp.err == exp_err[0])
        else stop_on_error($sformatf("mismatch ps_rsp_o.err expected %h actual %h",
                                     exp_err[0], $sampled(ps_rsp.err)));
    a_eth_rsp_err: assert property (@(posedge ps_clk) disable iff (!arst_n)
        eth_rsp.ack |-> eth_rsp.err == exp_err[1])
        else stop_on_error($sformatf("mismatch eth_rsp_o.err expected %h actual %h",
                                     exp_err[1], $sampled(eth_rsp.err)));
    a_ps_rsp_dat: assert property (@(posedge ps_clk) disable iff (!arst_n)
        ps_rsp.ack && chk_dat[0] |-> ps_rsp.dat == exp_dat[0])
        else stop_on_error($sformatf("mismatch ps_rsp_o.dat expected %h actual %h",
                                     exp_dat[0], $sampled(ps_rsp.dat)));
    a_eth_rsp_dat: assert property (@(posedge ps_clk) disable iff (!arst_n)
        eth_rsp.ack && chk_dat[1] |-> eth_rsp.dat == exp_dat[1])
        else stop_on_error($sformatf("mismatch eth_rsp_o.dat expected %h actual %h",
                                     exp_dat[1], $sampled(eth_rsp.dat)));
    // Commands only for accesses that should be forwarded
    a_cmd_allowed: assert property (@(posedge ps_clk) disable iff (!arst_n)
        link_cmd.valid |-> cmd_allowed)
        else stop_on_error("link command issued without a forwarded crate access");
    a_cmd_fields: assert property (@(posedge ps_clk) disable iff (!arst_n)
        link_cmd.valid |-> link_cmd == exp_cmd)
        else stop_on_error($sformatf("mismatch link_cmd_o expected %h actual %h",
                                     exp_cmd, $sampled(link_cmd)));
    a_cmd_pulse: assert property (@(posedge ps_clk) disable iff (!arst_n)
        link_cmd.valid |=> !link_cmd.valid)
        else stop_on_error("link command valid lasted longer than one cycle");
    // Ack one cycle after the link answers
    a_ack_after_link: assert property (@(posedge ps_clk) disable iff (!arst_n)
        link_rsp.valid |=> (ps_rsp.ack || eth_rsp.ack))
        else stop_on_error("no ack one cycle after the link response");

    //////////////////////////////////////////////////
    // Link model and watchdog
    //////////////////////////////////////////////////

    // Answers each command after 1 to 20 cycles unless silenced
    initial begin : link_model
        turf_wb_pkg::link_cmd_t cmd;
        int                     delay;
        forever begin
            @(negedge ps_clk);
            if (link_cmd.valid && !link_silent) begin
                cmd   = link_cmd;
                delay = 1 + (($random(seed) & 32'h7FFF_FFFF) % 20);
                repeat (delay) @(posedge ps_clk);
                #1;
                link_rsp.valid = 1'b1;
                link_rsp.dat   = link_reply_word(cmd);
                @(posedge ps_clk);
                #1;
                link_rsp = '0;
            end
        end
    end

    // Six tests, each given a timeout plus margin
    initial begin : watchdog
        repeat (6 * (turf_id_pkg::BRIDGE_TIMEOUT + 100)) @(posedge ps_clk);
        stop_on_error("watchdog expired before the tests completed");
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        ps_clk      = 1'b0;
        arst_n      = 1'b0;
        ps_req      = '0;
        eth_req     = '0;
        aurora_up   = 4'hF;
        link_rsp    = '0;
        exp_cmd     = '0;
        cmd_allowed = 1'b0;
        link_silent = 1'b0;
        for (int m = 0; m < 2; m++) begin
            exp_dat[m] = '0;
            exp_err[m] = 1'b0;
            chk_dat[m] = 1'b0;
        end
        repeat (5) @(posedge ps_clk);
        #1;
        assert (!ps_rsp.ack && !eth_rsp.ack && !ps_rsp.err && !eth_rsp.err && !link_cmd.valid)
        else stop_on_error("outputs not idle after reset");
        arst_n = 1'b1;

        // Identity words and reset state, 2 cycles each
        bus_access(0, 1'b0, 28'h000_0000, '0, 32'h5455_5246, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_0004, '0, 32'h0000_0201, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_0008, '0, 32'h0000_0000, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0000, 1'b0, 2);

        // Refused while type is none, link 0 invalid flag
        bus_access(1, 1'b0, 28'h800_0010, '0, 32'hFFFF_FFFF, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0010, 1'b0, 2);
        bus_access(0, 1'b1, 28'h000_000C, 32'h10, '0, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0000, 1'b0, 2);
        // Refused with link 2 down
        bus_access(0, 1'b1, 28'h000_0008, 32'h21, '0, 1'b0, 2);
        aurora_up = 4'b1011;
        bus_access(1, 1'b1, 28'h800_0020, 32'h1234_5678, '0, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0040, 1'b0, 2);
        bus_access(0, 1'b1, 28'h000_000C, 32'h40, '0, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0000, 1'b0, 2);
        aurora_up = 4'hF;

        // Control readback, then forwarded write on link 1
        bus_access(0, 1'b1, 28'h000_0008, 32'h11, '0, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_0008, '0, 32'h0000_0011, 1'b0, 2);
        expect_cmd(1'b1, 2'd1, 28'h800_0124, 32'hCAFE_F00D);
        cmd_allowed = 1'b1;
        bus_access(1, 1'b1, 28'h800_0124, 32'hCAFE_F00D, '0, 1'b0, -1);
        cmd_allowed = 1'b0;
        // Forwarded reads over every link
        for (int i = 0; i < 4; i++) begin
            bus_access(0, 1'b1, 28'h000_0008, {26'h0, i[1:0], 4'h1}, '0, 1'b0, 2);
            rnd_adr = {1'b1, 25'($random(seed)), 2'b00};
            expect_cmd(1'b0, i[1:0], rnd_adr, 32'h0);
            cmd_allowed = 1'b1;
            bus_access(1, 1'b0, rnd_adr, '0, link_reply_word(exp_cmd), 1'b0, -1);
            cmd_allowed = 1'b0;
        end

        // Silent link 3 times out
        // Grant and command take a cycle each before the timeout runs
        link_silent = 1'b1;
        expect_cmd(1'b0, 2'd3, 28'h800_0300, 32'h0);
        cmd_allowed = 1'b1;
        bus_access(1, 1'b0, 28'h800_0300, '0, 32'hFFFF_FFFF, 1'b0,
                   turf_id_pkg::BRIDGE_TIMEOUT + 2);
        cmd_allowed = 1'b0;
        link_silent = 1'b0;
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0008, 1'b0, 2);
        bus_access(0, 1'b1, 28'h000_000C, 32'h08, '0, 1'b0, 2);
        bus_access(0, 1'b0, 28'h000_000C, '0, 32'h0000_0000, 1'b0, 2);

        // Unmapped space
        bus_access(0, 1'b0, 28'h000_4000, '0, 32'h0000_0000, 1'b1, 2);
        bus_access(1, 1'b0, 28'h7FF_FFFC, '0, 32'h0000_0000, 1'b1, 2);

        // Both masters at once, grants must alternate
        served.delete();
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    bus_access(0, 1'b0, (i % 2) ? 28'h000_0004 : 28'h000_0000, '0,
                               (i % 2) ? 32'h0000_0201 : 32'h5455_5246, 1'b0, -1);
                end
            end
            begin
                for (int i = 0; i < 6; i++) begin
                    bus_access(1, 1'b0, (i % 2) ? 28'h000_0000 : 28'h000_0004, '0,
                               (i % 2) ? 32'h5455_5246 : 32'h0000_0201, 1'b0, -1);
                end
            end
        join
        for (int i = 1; i < served.size(); i++) begin
            assert (served[i] != served[i-1])
            else stop_on_error("accesses did not alternate between the masters");
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: turf_regs.f
design/turf_wb_pkg.sv
design/turf_id_pkg.sv
design/turf_wb_arbiter.sv
design/turf_wb_decoder.sv
design/turf_id_ctrl.sv
design/turfio_register_bridge.sv
design/turf_regs_top.sv
verification/turf_regs_tb.sv
